//--- alu_pkg.sv
// rv64 alu shared definitions
`default_nettype none

package alu_pkg;

	// datapath widths
	localparam int XLEN = 64;
	localparam int WORD_W = 32;
	localparam int SHAMT_W = $clog2(XLEN);
	// fold depth of the comparator tree
	localparam int CMP_LEVELS = $clog2(XLEN);

	// funct3 codes shared by op, op-imm and their word forms
	localparam logic [2:0] F3_ADD = 3'b000;
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_SR = 3'b101;
	localparam logic [2:0] F3_OR = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	// funct7 values, alt selects sub and sra
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT = 7'b0100000;

	// operand and result word
	typedef logic [XLEN-1:0] xlen_t;
	// halfword aligned pc, bit 0 is implied zero
	typedef logic [XLEN-1:1] pc_t;

	// major opcodes, inst[6:2]
	typedef enum logic [4:0] {
		OPC_LOAD = 5'b00000,
		OPC_OP_IMM = 5'b00100,
		OPC_AUIPC = 5'b00101,
		OPC_OP_IMM_32 = 5'b00110,
		OPC_STORE = 5'b01000,
		OPC_OP = 5'b01100,
		OPC_LUI = 5'b01101,
		OPC_OP_32 = 5'b01110,
		OPC_BRANCH = 5'b11000,
		OPC_JALR = 5'b11001,
		OPC_JAL = 5'b11011,
		OPC_SYSTEM = 5'b11100
	} opcode_e;

	// where rd comes from in execute
	typedef enum logic [3:0] {
		ADD,
		ADDW,
		SLL,
		SLLW,
		SR,
		SRW,
		SLT,
		XOR,
		OR,
		AND,
		// lui immediate
		IMM,
		// return address for jal and jalr
		LINK,
		// no rd write, also used for illegal encodings
		BRANCH
	} alu_op_e;

	// one immediate word, read as a value or as a shift encoding
	typedef union packed {
		// sign-extended i/u/b/j immediate, low 32 bits
		logic [31:0] word;
		// shift view, upper acts as funct7 and upper[0] doubles as shamt[5]
		struct packed {
			logic [19:0] rest;
			logic [6:0] upper;
			logic [4:0] shamt_lo;
		} sh;
	} imm_word_u;

endpackage

`default_nettype wire

//--- alu_compare.sv
// rv64 tree comparator
`timescale 1ns/10ps
`default_nettype none

module alu_compare (
	input alu_pkg::xlen_t arg1_i,
	input alu_pkg::xlen_t arg2_i,
	input logic signed_i,
	output logic lt_o,
	output logic eq_o
);
	import alu_pkg::*;

	// per-bit partials, folded in place one level at a time
	xlen_t lt_v;
	xlen_t eq_v;

	always_comb begin
		// leaf less-than: arg1 bit 0 and arg2 bit 1
		lt_v = ~arg1_i & arg2_i;
		eq_v = ~(arg1_i ^ arg2_i);
		// sign bit has the opposite sense
		// only the topmost leaf is ever signed
		if (signed_i)
			lt_v[XLEN-1] = arg1_i[XLEN-1] & ~arg2_i[XLEN-1];

		// halve each level, pair n is bits 2n+1 (high) and 2n (low)
		for (int l = 0; l < CMP_LEVELS; l++) begin
			for (int n = 0; n < (XLEN >> (l + 1)); n++) begin
				// high half wins unless it is equal
				lt_v[n] = lt_v[2*n+1] | (eq_v[2*n+1] & lt_v[2*n]);
				eq_v[n] = eq_v[2*n+1] & eq_v[2*n];
			end
		end

		// root of the tree
		lt_o = lt_v[0];
		eq_o = eq_v[0];
	end

endmodule

`default_nettype wire

//--- alu_shift.sv
// rv64 barrel shifter
`timescale 1ns/10ps
`default_nettype none

module alu_shift (
	input alu_pkg::xlen_t value_i,
	input logic [alu_pkg::SHAMT_W-1:0] shamt_i,
	input logic arith_i,
	output alu_pkg::xlen_t sll_o,
	output alu_pkg::xlen_t sllw_o,
	output alu_pkg::xlen_t sr_o,
	output alu_pkg::xlen_t srw_o
);
	import alu_pkg::*;

	xlen_t sll_v;
	xlen_t sr_v;
	xlen_t fill_v;
	logic [WORD_W-1:0] sllw_v;
	logic [WORD_W-1:0] srw_v;
	logic [WORD_W-1:0] fillw_v;

	always_comb begin
		sll_v = value_i;
		sr_v = value_i;
		sllw_v = value_i[WORD_W-1:0];
		srw_v = value_i[WORD_W-1:0];
		// sign fill, all zero for logical shifts
		fill_v = {XLEN{arith_i & value_i[XLEN-1]}};
		fillw_v = {WORD_W{arith_i & value_i[WORD_W-1]}};

		// one stage per shamt bit, stage i moves by 2**i
		for (int i = 0; i < SHAMT_W; i++) begin
			if (shamt_i[i]) begin
				sll_v = sll_v << (1 << i);
				// vacated top bits take the fill
				sr_v = (sr_v >> (1 << i)) | (fill_v & ~(xlen_t'('1) >> (1 << i)));
				// word forms stop at 5 bits of shamt
				if (i < SHAMT_W - 1) begin
					sllw_v = sllw_v << (1 << i);
					srw_v = (srw_v >> (1 << i)) |
						(fillw_v & ~({WORD_W{1'b1}} >> (1 << i)));
				end
			end
		end
	end

	assign sll_o = sll_v;
	assign sr_o = sr_v;
	// word results sign-extend from bit 31
	assign sllw_o = {{(XLEN - WORD_W){sllw_v[WORD_W-1]}}, sllw_v};
	assign srw_o = {{(XLEN - WORD_W){srw_v[WORD_W-1]}}, srw_v};

endmodule

`default_nettype wire

//--- alu_decode.sv
// rv64 alu decode stage
`timescale 1ns/10ps
`default_nettype none

module alu_decode (
	input logic clk_i,
	input logic rst_n_i,
	input logic valid_i,
	input logic [4:0] opcode_i,
	input logic [2:0] funct3_i,
	input logic [6:0] funct7_i,
	input alu_pkg::xlen_t rs1_i,
	input alu_pkg::xlen_t rs2_i,
	input alu_pkg::imm_word_u imm_i,
	input alu_pkg::pc_t pc_i,
	input alu_pkg::pc_t pcnext_i,
	output logic dec_valid_o,
	output logic dec_sigill_o,
	output alu_pkg::alu_op_e dec_op_o,
	output alu_pkg::xlen_t dec_in1_o,
	output alu_pkg::xlen_t dec_in2_o,
	output logic dec_cin_o,
	output alu_pkg::xlen_t dec_in3_o,
	output alu_pkg::xlen_t dec_in4_o,
	output logic dec_cmp_signed_o,
	output logic dec_shift_arith_o,
	output logic dec_br_use_eq_o,
	output logic dec_br_invert_o,
	output logic dec_jump_always_o,
	output alu_pkg::pc_t dec_pcnext_o
);
	import alu_pkg::*;

	xlen_t imm64;
	logic reg_op;
	logic word_op;
	logic alt;
	logic f7_ok;
	logic [6:0] upper_chk;
	logic [SHAMT_W-1:0] imm_shamt;
	// next values of the stage register
	logic sigill;
	alu_op_e op;
	xlen_t in1;
	xlen_t in2;
	xlen_t in3;
	xlen_t in4;
	logic cin;
	logic cmp_signed;
	logic jump_always;

	assign imm64 = {{(XLEN - 32){imm_i.word[31]}}, imm_i.word};
	assign reg_op = (opcode_i == OPC_OP) || (opcode_i == OPC_OP_32);
	assign word_op = (opcode_i == OPC_OP_32) || (opcode_i == OPC_OP_IMM_32);
	// sub / sra flag, funct7 for register forms, shift view for immediates
	assign alt = reg_op ? funct7_i[5] : imm_i.sh.upper[5];
	assign imm_shamt = {imm_i.sh.upper[0], imm_i.sh.shamt_lo};
	// alt funct7 only valid on add and right shift
	assign f7_ok = (funct7_i == F7_BASE) ||
		(funct7_i == F7_ALT && (funct3_i == F3_ADD || funct3_i == F3_SR));

	// bits of the upper field that must be zero for an immediate shift
	always_comb begin
		upper_chk = imm_i.sh.upper;
		// arithmetic flag
		if (funct3_i == F3_SR)
			upper_chk[5] = 1'b0;
		// shamt[5] on full width only
		if (!word_op)
			upper_chk[0] = 1'b0;
	end

	always_comb begin
		sigill = 1'b0;
		op = ADD;
		in1 = rs1_i;
		in2 = imm64;
		cin = 1'b0;
		in3 = rs1_i;
		in4 = imm64;
		// slt vs sltu
		cmp_signed = ~funct3_i[0];
		jump_always = 1'b0;

		unique case (opcode_e'(opcode_i))
			OPC_OP_IMM, OPC_OP_IMM_32, OPC_OP, OPC_OP_32: begin
				// rs2 replaces imm, sub adds the inverse plus one
				if (reg_op) begin
					in2 = alt ? ~rs2_i : rs2_i;
					cin = alt;
					in4 = rs2_i;
					sigill = ~f7_ok;
				end
				unique case (funct3_i)
					F3_ADD:
						op = word_op ? ADDW : ADD;
					F3_SLL:
						op = word_op ? SLLW : SLL;
					F3_SR:
						op = word_op ? SRW : SR;
					F3_SLT, F3_SLTU:
						op = SLT;
					F3_XOR:
						op = XOR;
					F3_OR:
						op = OR;
					default:
						op = AND;
				endcase
				// compare and logic have no word form
				if (word_op && !(funct3_i inside {F3_ADD, F3_SLL, F3_SR}))
					sigill = 1'b1;
				// immediate shifts read shamt from the shift view
				if (!reg_op && (funct3_i == F3_SLL || funct3_i == F3_SR)) begin
					in4 = xlen_t'(imm_shamt);
					if (upper_chk != '0)
						sigill = 1'b1;
				end
			end
			OPC_LUI:
				op = IMM;
			OPC_AUIPC:
				in1 = {pc_i, 1'b0};
			OPC_BRANCH: begin
				// target on the adder, condition on the comparator
				op = BRANCH;
				in1 = {pc_i, 1'b0};
				in4 = rs2_i;
				cmp_signed = ~funct3_i[1];
				// funct3 2 and 3 unused
				sigill = (funct3_i[2:1] == 2'b01);
			end
			OPC_JAL: begin
				op = LINK;
				in1 = {pc_i, 1'b0};
				jump_always = 1'b1;
			end
			OPC_JALR: begin
				op = LINK;
				jump_always = 1'b1;
				sigill = (funct3_i != 3'b000);
			end
			// loads, stores, csr and anything else
			default:
				sigill = 1'b1;
		endcase

		// illegal: no rd and no redirect
		if (sigill) begin
			op = BRANCH;
			jump_always = 1'b0;
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			dec_valid_o <= 1'b0;
			dec_sigill_o <= 1'b0;
		end else begin
			dec_valid_o <= valid_i;
			dec_sigill_o <= valid_i & sigill;
		end
	end

	// operands only move on a strobe
	always_ff @(posedge clk_i) begin
		if (valid_i) begin
			dec_op_o <= op;
			dec_in1_o <= in1;
			dec_in2_o <= in2;
			dec_cin_o <= cin;
			dec_in3_o <= in3;
			dec_in4_o <= in4;
			dec_cmp_signed_o <= cmp_signed;
			dec_shift_arith_o <= alt;
			// beq/bne test eq, the rest lt, odd funct3 inverts
			dec_br_use_eq_o <= ~funct3_i[2];
			dec_br_invert_o <= funct3_i[0];
			dec_jump_always_o <= jump_always;
			dec_pcnext_o <= pcnext_i;
		end
	end

	// an illegal strobe never reaches execute as a jump
	a_sigill_no_jump: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		valid_i && sigill |=> dec_sigill_o && !dec_jump_always_o);

endmodule

`default_nettype wire

//--- alu_execute.sv
// rv64 alu execute stage
`timescale 1ns/10ps
`default_nettype none

module alu_execute (
	input logic clk_i,
	input logic rst_n_i,
	input logic dec_valid_i,
	input logic dec_sigill_i,
	input alu_pkg::alu_op_e dec_op_i,
	input alu_pkg::xlen_t dec_in1_i,
	input alu_pkg::xlen_t dec_in2_i,
	input logic dec_cin_i,
	input alu_pkg::xlen_t dec_in3_i,
	input alu_pkg::xlen_t dec_in4_i,
	input logic dec_cmp_signed_i,
	input logic dec_shift_arith_i,
	input logic dec_br_use_eq_i,
	input logic dec_br_invert_i,
	input logic dec_jump_always_i,
	input alu_pkg::pc_t dec_pcnext_i,
	output logic valid_o,
	output logic sigill_o,
	output alu_pkg::xlen_t rd_o,
	output alu_pkg::pc_t pcnext_o
);
	import alu_pkg::*;

	xlen_t sum;
	xlen_t sum_w;
	xlen_t and_v;
	xlen_t or_v;
	xlen_t xor_v;
	xlen_t sll;
	xlen_t sllw;
	xlen_t sr;
	xlen_t srw;
	xlen_t rd_next;
	logic lt;
	logic eq;
	logic cond;
	logic jump;
	pc_t pcnext_next;

	// adder, carry in completes the two's complement for sub
	assign sum = dec_in1_i + dec_in2_i + xlen_t'(dec_cin_i);
	assign sum_w = {{(XLEN - WORD_W){sum[WORD_W-1]}}, sum[WORD_W-1:0]};

	// logic unit on the misc operands
	assign and_v = dec_in3_i & dec_in4_i;
	assign or_v = dec_in3_i | dec_in4_i;
	assign xor_v = dec_in3_i ^ dec_in4_i;

	alu_compare u_compare (
		.arg1_i(dec_in3_i),
		.arg2_i(dec_in4_i),
		.signed_i(dec_cmp_signed_i),
		.lt_o(lt),
		.eq_o(eq)
	);

	// shamt is the low bits of in4, rs2 or the immediate
	alu_shift u_shift (
		.value_i(dec_in3_i),
		.shamt_i(dec_in4_i[SHAMT_W-1:0]),
		.arith_i(dec_shift_arith_i),
		.sll_o(sll),
		.sllw_o(sllw),
		.sr_o(sr),
		.srw_o(srw)
	);

	// branch outcome, inverted for bne / bge / bgeu
	assign cond = (dec_br_use_eq_i ? eq : lt) ^ dec_br_invert_i;
	assign jump = dec_jump_always_i | ((dec_op_i == BRANCH) & ~dec_sigill_i & cond);
	// taken target drops bit 0, which also clears it for jalr
	assign pcnext_next = jump ? sum[XLEN-1:1] : dec_pcnext_i;

	always_comb begin
		unique case (dec_op_i)
			ADD: rd_next = sum;
			ADDW: rd_next = sum_w;
			SLL: rd_next = sll;
			SLLW: rd_next = sllw;
			SR: rd_next = sr;
			SRW: rd_next = srw;
			SLT: rd_next = xlen_t'(lt);
			XOR: rd_next = xor_v;
			OR: rd_next = or_v;
			AND: rd_next = and_v;
			IMM: rd_next = dec_in2_i;
			// return address as a byte address
			LINK: rd_next = {dec_pcnext_i, 1'b0};
			// branches and illegal encodings
			default: rd_next = '0;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_o <= 1'b0;
			sigill_o <= 1'b0;
		end else begin
			valid_o <= dec_valid_i;
			sigill_o <= dec_valid_i & dec_sigill_i;
		end
	end

	// result held until the next operation
	always_ff @(posedge clk_i) begin
		if (dec_valid_i) begin
			rd_o <= rd_next;
			pcnext_o <= pcnext_next;
		end
	end

	// exactly one stage of latency
	a_valid_rise: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		dec_valid_i |=> valid_o);
	a_valid_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!dec_valid_i |=> !valid_o);
	// decode turns illegal encodings into a no-rd op
	a_sigill_rd_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		sigill_o |-> rd_o == '0);

endmodule

`default_nettype wire

//--- rv_alu_top.sv
// rv64 pipelined alu top
`timescale 1ns/10ps
`default_nettype none

module rv_alu_top (
	input logic clk_i,
	input logic rst_n_i,
	input logic valid_i,
	input logic [4:0] opcode_i,
	input logic [2:0] funct3_i,
	input logic [6:0] funct7_i,
	input alu_pkg::xlen_t rs1_i,
	input alu_pkg::xlen_t rs2_i,
	input alu_pkg::imm_word_u imm_i,
	input alu_pkg::pc_t pc_i,
	input alu_pkg::pc_t pcnext_i,
	output logic valid_o,
	output logic sigill_o,
	output alu_pkg::xlen_t rd_o,
	output alu_pkg::pc_t pcnext_o
);
	import alu_pkg::*;

	// stage one register outputs
	logic dec_valid;
	logic dec_sigill;
	alu_op_e dec_op;
	xlen_t dec_in1;
	xlen_t dec_in2;
	logic dec_cin;
	xlen_t dec_in3;
	xlen_t dec_in4;
	logic dec_cmp_signed;
	logic dec_shift_arith;
	logic dec_br_use_eq;
	logic dec_br_invert;
	logic dec_jump_always;
	pc_t dec_pcnext;

	alu_decode u_decode (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.valid_i(valid_i),
		.opcode_i(opcode_i),
		.funct3_i(funct3_i),
		.funct7_i(funct7_i),
		.rs1_i(rs1_i),
		.rs2_i(rs2_i),
		.imm_i(imm_i),
		.pc_i(pc_i),
		.pcnext_i(pcnext_i),
		.dec_valid_o(dec_valid),
		.dec_sigill_o(dec_sigill),
		.dec_op_o(dec_op),
		.dec_in1_o(dec_in1),
		.dec_in2_o(dec_in2),
		.dec_cin_o(dec_cin),
		.dec_in3_o(dec_in3),
		.dec_in4_o(dec_in4),
		.dec_cmp_signed_o(dec_cmp_signed),
		.dec_shift_arith_o(dec_shift_arith),
		.dec_br_use_eq_o(dec_br_use_eq),
		.dec_br_invert_o(dec_br_invert),
		.dec_jump_always_o(dec_jump_always),
		.dec_pcnext_o(dec_pcnext)
	);

	// second stage registers rd and next pc
	alu_execute u_execute (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.dec_valid_i(dec_valid),
		.dec_sigill_i(dec_sigill),
		.dec_op_i(dec_op),
		.dec_in1_i(dec_in1),
		.dec_in2_i(dec_in2),
		.dec_cin_i(dec_cin),
		.dec_in3_i(dec_in3),
		.dec_in4_i(dec_in4),
		.dec_cmp_signed_i(dec_cmp_signed),
		.dec_shift_arith_i(dec_shift_arith),
		.dec_br_use_eq_i(dec_br_use_eq),
		.dec_br_invert_i(dec_br_invert),
		.dec_jump_always_i(dec_jump_always),
		.dec_pcnext_i(dec_pcnext),
		.valid_o(valid_o),
		.sigill_o(sigill_o),
		.rd_o(rd_o),
		.pcnext_o(pcnext_o)
	);

endmodule

`default_nettype wire

//--- tb_rv_alu.sv
// rv64 alu directed testbench
`timescale 1ns/10ps
`default_nettype none

module tb_rv_alu;
	import alu_pkg::*;

	// strobes per test in run order, arith shift compare branch misc stream
	localparam int N_STROBES = 25 + 72 + 15 + 22 + 10 + 10;
	localparam int CYCLE_LIMIT = 2 * N_STROBES + 50;

	logic clk_i;
	logic rst_n_i;
	logic valid_i;
	logic [4:0] opcode_i;
	logic [2:0] funct3_i;
	logic [6:0] funct7_i;
	xlen_t rs1_i;
	xlen_t rs2_i;
	imm_word_u imm_i;
	pc_t pc_i;
	pc_t pcnext_i;
	logic valid_o;
	logic sigill_o;
	xlen_t rd_o;
	pc_t pcnext_o;

	// expected results, oldest strobe first
	xlen_t q_rd[$];
	pc_t q_pc[$];
	bit q_ill[$];
	int q_cyc[$];

	int cycles = 0;
	int n_checks = 0;
	int n_errors = 0;

	rv_alu_top u_dut (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.valid_i(valid_i),
		.opcode_i(opcode_i),
		.funct3_i(funct3_i),
		.funct7_i(funct7_i),
		.rs1_i(rs1_i),
		.rs2_i(rs2_i),
		.imm_i(imm_i),
		.pc_i(pc_i),
		.pcnext_i(pcnext_i),
		.valid_o(valid_o),
		.sigill_o(sigill_o),
		.rd_o(rd_o),
		.pcnext_o(pcnext_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;
	end

	// cycle count, also stops a stuck run
	always @(posedge clk_i) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run stopped after %0d cycles", cycles);
			$display("Result: FAILED");
			$finish;
		end
	end

	function automatic xlen_t rand64();
		return {$urandom, $urandom};
	endfunction

	function automatic logic [31:0] imm12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	function automatic xlen_t sext32(input logic [31:0] v);
		return {{32{v[31]}}, v};
	endfunction

	// expected rd, next pc and sigill from the rv64i rules
	function automatic void ref_model(input logic [4:0] opc, input logic [2:0] f3,
		input logic [6:0] f7, input xlen_t a, input xlen_t b, input logic [31:0] iw,
		input pc_t pc, input pc_t pn, output xlen_t rd, output pc_t npc, output bit ill);
		xlen_t imm;
		xlen_t src2;
		xlen_t target;
		logic [5:0] sh;
		logic [31:0] w;
		bit word;
		bit reg_form;
		bit alt;
		bit taken;
		imm = sext32(iw);
		word = (opc == OPC_OP_32) || (opc == OPC_OP_IMM_32);
		reg_form = (opc == OPC_OP) || (opc == OPC_OP_32);
		src2 = reg_form ? b : imm;
		sh = word ? {1'b0, src2[4:0]} : src2[5:0];
		rd = '0;
		npc = pn;
		ill = 1'b0;
		taken = 1'b0;
		target = '0;
		case (opc)
			OPC_OP, OPC_OP_32, OPC_OP_IMM, OPC_OP_IMM_32: begin
				// imm[10] is funct7 bit 5 for immediate shifts
				alt = reg_form ? f7[5] : iw[10];
				if (reg_form)
					ill = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)));
				else if (f3 == 3'b001)
					ill = word ? (iw[11:5] != 7'h00) : (iw[11:6] != 6'h00);
				else if (f3 == 3'b101)
					ill = word ? (iw[11:5] != 7'h00 && iw[11:5] != 7'h20) :
						(iw[11:6] != 6'h00 && iw[11:6] != 6'h10);
				// no word form of compare or logic
				if (word && !(f3 == 3'b000 || f3 == 3'b001 || f3 == 3'b101))
					ill = 1'b1;
				case (f3)
					3'b000: rd = (reg_form && alt) ? a - b : a + src2;
					3'b001: rd = a << sh;
					3'b010: rd = ($signed(a) < $signed(src2)) ? 64'd1 : 64'd0;
					3'b011: rd = (a < src2) ? 64'd1 : 64'd0;
					3'b100: rd = a ^ src2;
					3'b101: begin
						if (alt)
							rd = $signed(a) >>> sh;
						else
							rd = a >> sh;
					end
					3'b110: rd = a | src2;
					default: rd = a & src2;
				endcase
				// W forms work on the low word
				if (word) begin
					w = rd[31:0];
					if (f3 == 3'b001)
						w = a[31:0] << sh[4:0];
					if (f3 == 3'b101 && alt)
						w = $signed(a[31:0]) >>> sh[4:0];
					if (f3 == 3'b101 && !alt)
						w = a[31:0] >> sh[4:0];
					rd = sext32(w);
				end
			end
			OPC_LUI:
				rd = imm;
			OPC_AUIPC:
				rd = {pc, 1'b0} + imm;
			OPC_JAL, OPC_JALR: begin
				ill = (opc == OPC_JALR) && (f3 != 3'b000);
				target = (opc == OPC_JAL) ? {pc, 1'b0} + imm : a + imm;
				// link is the sequential pc
				rd = {pn, 1'b0};
				taken = 1'b1;
			end
			OPC_BRANCH: begin
				case (f3)
					3'b000: taken = (a == b);
					3'b001: taken = (a != b);
					3'b100: taken = ($signed(a) < $signed(b));
					3'b101: taken = ($signed(a) >= $signed(b));
					3'b110: taken = (a < b);
					3'b111: taken = (a >= b);
					default: ill = 1'b1;
				endcase
				target = {pc, 1'b0} + imm;
			end
			default:
				ill = 1'b1;
		endcase
		if (taken)
			npc = target[XLEN-1:1];
		if (ill) begin
			rd = '0;
			npc = pn;
		end
	endfunction

	task automatic check_rd(input xlen_t exp, input xlen_t act);
		n_checks++;
		if (act !== exp) begin
			$display("mismatch rd_o: expected %h, got %h", exp, act);
			n_errors++;
		end
	endtask

	task automatic check_pc(input pc_t exp, input pc_t act);
		n_checks++;
		if (act !== exp) begin
			$display("mismatch pcnext_o: expected %h, got %h", exp, act);
			n_errors++;
		end
	endtask

	task automatic check_flag(input string name, input bit exp, input logic act);
		n_checks++;
		if (act !== exp) begin
			$display("mismatch %s: expected %h, got %h", name, exp, act);
			n_errors++;
		end
	endtask

	task automatic drop_front();
		void'(q_rd.pop_front());
		void'(q_pc.pop_front());
		void'(q_ill.pop_front());
		void'(q_cyc.pop_front());
	endtask

	// outputs are stable at the falling edge
	always @(negedge clk_i) begin
		if (rst_n_i) begin
			if (valid_o) begin
				if (q_rd.size() == 0) begin
					$display("valid_o raised with no operation pending, cycle %0d", cycles);
					n_errors++;
				end else begin
					if (cycles - q_cyc[0] != 2) begin
						$display("result came %0d cycles after its strobe, not 2",
							cycles - q_cyc[0]);
						n_errors++;
					end
					check_flag("sigill_o", q_ill[0], sigill_o);
					check_rd(q_rd[0], rd_o);
					check_pc(q_pc[0], pcnext_o);
					drop_front();
				end
			end else if (q_rd.size() != 0 && cycles - q_cyc[0] >= 2) begin
				$display("no result for the strobe of cycle %0d", q_cyc[0]);
				n_errors++;
				drop_front();
			end
		end
	end

	// one strobe on the next falling edge, random pc
	task automatic issue(input logic [4:0] opc, input logic [2:0] f3, input logic [6:0] f7,
		input xlen_t a, input xlen_t b, input logic [31:0] iw);
		xlen_t r;
		pc_t pc;
		pc_t pn;
		xlen_t rd;
		pc_t npc;
		bit ill;
		r = rand64();
		pc = r[XLEN-1:1];
		pn = pc + 63'd2;
		ref_model(opc, f3, f7, a, b, iw, pc, pn, rd, npc, ill);
		@(negedge clk_i);
		valid_i = 1'b1;
		opcode_i = opc;
		funct3_i = f3;
		funct7_i = f7;
		rs1_i = a;
		rs2_i = b;
		imm_i.word = iw;
		pc_i = pc;
		pcnext_i = pn;
		q_rd.push_back(rd);
		q_pc.push_back(npc);
		q_ill.push_back(ill);
		q_cyc.push_back(cycles);
	endtask

	// stop strobing, wait for the pipe to empty
	task automatic finish_test(input string name, input int e0, input int c0);
		@(negedge clk_i);
		valid_i = 1'b0;
		while (q_rd.size() != 0)
			@(posedge clk_i);
		$display("%s: %0d checks, %0d errors", name, n_checks - c0, n_errors - e0);
	endtask

	task automatic test_arith();
		int e0;
		int c0;
		xlen_t a;
		xlen_t b;
		logic [31:0] iw;
		e0 = n_errors;
		c0 = n_checks;
		// wrap-around and word sign-extension
		issue(OPC_OP, 3'b000, 7'h00, '1, 64'd1, '0);
		issue(OPC_OP, 3'b000, 7'h20, '0, 64'd1, '0);
		issue(OPC_OP_IMM, 3'b000, 7'h00, 64'd5, '0, 32'hffff_f800);
		issue(OPC_OP_32, 3'b000, 7'h00, 64'h0000_0000_7fff_ffff, 64'd1, '0);
		issue(OPC_OP_32, 3'b000, 7'h20, 64'hffff_ffff_8000_0000, 64'd1, '0);
		for (int i = 0; i < 4; i++) begin
			a = rand64();
			b = rand64();
			iw = imm12(12'($urandom));
			issue(OPC_OP, 3'b000, 7'h00, a, b, '0);
			issue(OPC_OP, 3'b000, 7'h20, a, b, '0);
			issue(OPC_OP_IMM, 3'b000, 7'h00, a, '0, iw);
			issue(OPC_OP_32, 3'b000, 7'h00, a, b, '0);
			issue(OPC_OP_32, 3'b000, 7'h20, a, b, '0);
		end
		finish_test("add/sub", e0, c0);
	endtask

	// all twelve shift encodings at one amount
	task automatic shift_set(input xlen_t v, input logic [5:0] amt);
		xlen_t b;
		// upper rs2 bits must not matter
		b = (rand64() << 6) | xlen_t'(amt);
		issue(OPC_OP, 3'b001, 7'h00, v, b, '0);
		issue(OPC_OP, 3'b101, 7'h00, v, b, '0);
		issue(OPC_OP, 3'b101, 7'h20, v, b, '0);
		issue(OPC_OP_32, 3'b001, 7'h00, v, b, '0);
		issue(OPC_OP_32, 3'b101, 7'h00, v, b, '0);
		issue(OPC_OP_32, 3'b101, 7'h20, v, b, '0);
		issue(OPC_OP_IMM, 3'b001, 7'h00, v, '0, {26'd0, amt});
		issue(OPC_OP_IMM, 3'b101, 7'h00, v, '0, {26'd0, amt});
		issue(OPC_OP_IMM, 3'b101, 7'h00, v, '0, {21'd0, 1'b1, 4'd0, amt});
		// shamt 32 and up is illegal on the word immediates
		issue(OPC_OP_IMM_32, 3'b001, 7'h00, v, '0, {26'd0, amt});
		issue(OPC_OP_IMM_32, 3'b101, 7'h00, v, '0, {26'd0, amt});
		issue(OPC_OP_IMM_32, 3'b101, 7'h00, v, '0, {21'd0, 1'b1, 4'd0, amt});
	endtask

	task automatic test_shift();
		int e0;
		int c0;
		e0 = n_errors;
		c0 = n_checks;
		// sign bits set at 63 and 31
		shift_set(64'h8000_0000_8000_1234, 6'd0);
		shift_set(64'h8000_0000_8000_1234, 6'd31);
		shift_set(64'h8000_0000_8000_1234, 6'd32);
		shift_set(64'h8000_0000_8000_1234, 6'd63);
		for (int i = 0; i < 2; i++)
			shift_set(rand64(), 6'($urandom));
		finish_test("shifts", e0, c0);
	endtask

	task automatic test_compare();
		int e0;
		int c0;
		xlen_t p;
		xlen_t q;
		logic [31:0] iw;
		e0 = n_errors;
		c0 = n_checks;
		// differ only in the sign bit
		p = 64'h8000_0000_0000_0005;
		q = 64'h0000_0000_0000_0005;
		issue(OPC_OP, 3'b010, 7'h00, p, q, '0);
		issue(OPC_OP, 3'b011, 7'h00, p, q, '0);
		issue(OPC_OP, 3'b010, 7'h00, q, p, '0);
		issue(OPC_OP, 3'b011, 7'h00, q, p, '0);
		issue(OPC_OP, 3'b010, 7'h00, p, p, '0);
		issue(OPC_OP_IMM, 3'b010, 7'h00, 64'd1, '0, 32'hffff_ffff);
		issue(OPC_OP_IMM, 3'b011, 7'h00, 64'd1, '0, 32'hffff_ffff);
		issue(OPC_OP_IMM, 3'b010, 7'h00, '1, '0, 32'd1);
		issue(OPC_OP_IMM, 3'b011, 7'h00, '1, '0, 32'd1);
		p = rand64();
		q = rand64();
		issue(OPC_OP, 3'b100, 7'h00, p, q, '0);
		issue(OPC_OP, 3'b110, 7'h00, p, q, '0);
		issue(OPC_OP, 3'b111, 7'h00, p, q, '0);
		// negative immediates
		iw = imm12(12'h800 | 12'($urandom));
		issue(OPC_OP_IMM, 3'b100, 7'h00, p, '0, iw);
		issue(OPC_OP_IMM, 3'b110, 7'h00, p, '0, iw);
		issue(OPC_OP_IMM, 3'b111, 7'h00, p, '0, iw);
		finish_test("compare/logic", e0, c0);
	endtask

	task automatic test_branch();
		int e0;
		int c0;
		xlen_t p;
		xlen_t q;
		logic [31:0] iw;
		logic [31:0] r;
		e0 = n_errors;
		c0 = n_checks;
		// p below q signed, above q unsigned
		p = 64'hffff_ffff_ffff_fff0;
		q = 64'h0000_0000_0000_0010;
		for (int f = 0; f < 8; f++) begin
			if (f != 2 && f != 3) begin
				iw = imm12(12'($urandom) & 12'hffe);
				issue(OPC_BRANCH, 3'(f), 7'h00, p, p, iw);
				issue(OPC_BRANCH, 3'(f), 7'h00, p, q, iw);
				issue(OPC_BRANCH, 3'(f), 7'h00, q, p, iw);
			end
		end
		for (int i = 0; i < 2; i++) begin
			r = $urandom;
			issue(OPC_JAL, 3'b000, 7'h00, '0, '0, {{11{r[20]}}, r[20:1], 1'b0});
			// odd rs1 plus even imm checks the cleared bit 0
			issue(OPC_JALR, 3'b000, 7'h00, rand64() | 64'd1, '0,
				imm12(12'($urandom) & 12'hffe));
		end
		finish_test("branch/jump", e0, c0);
	endtask

	task automatic test_misc();
		int e0;
		int c0;
		e0 = n_errors;
		c0 = n_checks;
		issue(OPC_LUI, 3'b000, 7'h00, '0, '0, $urandom & 32'h7fff_f000);
		issue(OPC_LUI, 3'b000, 7'h00, '0, '0, ($urandom | 32'h8000_0000) & 32'hffff_f000);
		issue(OPC_AUIPC, 3'b000, 7'h00, '0, '0, $urandom & 32'h7fff_f000);
		issue(OPC_AUIPC, 3'b000, 7'h00, '0, '0, ($urandom | 32'h8000_0000) & 32'hffff_f000);
		// encodings outside the unit
		issue(OPC_LOAD, 3'b011, 7'h00, rand64(), '0, imm12(12'($urandom)));
		issue(OPC_SYSTEM, 3'b001, 7'h00, rand64(), '0, 32'h0000_0300);
		issue(OPC_OP, 3'b000, 7'h01, rand64(), rand64(), '0);
		issue(OPC_OP_IMM, 3'b001, 7'h00, rand64(), '0, 32'h0000_0403);
		issue(OPC_JALR, 3'b001, 7'h00, rand64(), '0, 32'd8);
		issue(OPC_OP_32, 3'b100, 7'h00, rand64(), rand64(), '0);
		finish_test("lui/auipc/sigill", e0, c0);
	endtask

	// back to back mix, latency checked per result
	task automatic test_stream();
		int e0;
		int c0;
		xlen_t a;
		e0 = n_errors;
		c0 = n_checks;
		a = rand64();
		issue(OPC_OP, 3'b000, 7'h00, rand64(), rand64(), '0);
		issue(OPC_OP, 3'b000, 7'h20, rand64(), rand64(), '0);
		issue(OPC_OP_IMM, 3'b001, 7'h00, rand64(), '0, 32'd13);
		issue(OPC_OP, 3'b010, 7'h00, rand64(), rand64(), '0);
		issue(OPC_OP_IMM, 3'b100, 7'h00, rand64(), '0, imm12(12'($urandom)));
		issue(OPC_BRANCH, 3'b000, 7'h00, a, a, 32'h0000_0040);
		issue(OPC_JAL, 3'b000, 7'h00, '0, '0, 32'hffff_ff00);
		issue(OPC_LUI, 3'b000, 7'h00, '0, '0, 32'h1234_5000);
		issue(OPC_LOAD, 3'b011, 7'h00, rand64(), '0, 32'd16);
		issue(OPC_OP_32, 3'b101, 7'h20, rand64(), 64'd7, '0);
		finish_test("pipeline stream", e0, c0);
	endtask

	initial begin
		void'($urandom(42141));
		rst_n_i = 1'b0;
		valid_i = 1'b0;
		opcode_i = '0;
		funct3_i = '0;
		funct7_i = '0;
		rs1_i = '0;
		rs2_i = '0;
		imm_i = '0;
		pc_i = '0;
		pcnext_i = '0;
		repeat (2) @(negedge clk_i);
		rst_n_i = 1'b1;
		check_flag("valid_o", 1'b0, valid_o);
		check_flag("sigill_o", 1'b0, sigill_o);
		test_arith();
		test_shift();
		test_compare();
		test_branch();
		test_misc();
		test_stream();
		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
alu_pkg.sv
alu_compare.sv
alu_shift.sv
alu_decode.sv
alu_execute.sv
rv_alu_top.sv
tb_rv_alu.sv

//--- run.sh
#!/bin/sh
# build and run the rv64 alu testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_alu -f list.f -o sim_rv_alu
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_rv_alu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
	exit 0
fi
exit 1
